/* source/ex_pkg.sv */
// ==============================
// Execute stage package
// Shared widths, operation codes and hold level
// for the RV64I execute stage
// ==============================
package ex_pkg;

	// Register file word and ALU operand width
	typedef logic [63:0] xlen_t;

	// Byte address presented to the data memory
	typedef logic [31:0] addr_t;

	// Index of the destination register in the writeback record
	typedef logic [4:0] reg_idx_t;

	// One enable bit per byte lane of a 64-bit word
	typedef logic [7:0] strb_t;

	// Hold level coming from the hazard unit
	typedef logic [2:0] hold_code_t;

	// The execute stage freezes at this hold level and at every level above it
	localparam hold_code_t HOLD_EX = 3'd2;

	// Data RAM depth in 64-bit words
	localparam int RAM_WORDS = 64;

	// Word index width, taken from address bits above the byte offset
	localparam int RAM_IDX_W = $clog2(RAM_WORDS);

	// ALU function, encoded as the RISC-V funct3 field
	// ADD doubles as SUB and SRL doubles as SRA through separate control bits
	typedef enum logic [2:0] {
		ALU_ADD  = 3'b000,
		ALU_SLL  = 3'b001,
		ALU_SLT  = 3'b010,
		ALU_SLTU = 3'b011,
		ALU_XOR  = 3'b100,
		ALU_SRL  = 3'b101,
		ALU_OR   = 3'b110,
		ALU_AND  = 3'b111
	} alu_op_e;

	// Load kind with its width and extension
	// The U forms zero-extend, the others sign-extend
	typedef enum logic [2:0] {
		LD_NONE = 3'd0,
		LB      = 3'd1,
		LH      = 3'd2,
		LW      = 3'd3,
		LD      = 3'd4,
		LBU     = 3'd5,
		LHU     = 3'd6,
		LWU     = 3'd7
	} load_code_e;

	// Store width
	typedef enum logic [2:0] {
		ST_NONE = 3'd0,
		SB      = 3'd1,
		SH      = 3'd2,
		SW      = 3'd3,
		SD      = 3'd4
	} store_code_e;

endpackage

/* source/mem_req_if.sv */
// ==============================
// Data memory request bundle
// One access per cycle from the execute unit
// to the data RAM, with no handshake
// ==============================
`timescale 1ns/10ps

interface mem_req_if
	import ex_pkg::*;
();

	// Read and write enables, never high together
	logic  rd_en;
	logic  wr_en;
	// Byte address of the access
	addr_t addr;
	// Store data, already moved to its byte lane
	xlen_t wdata;
	strb_t strb;
	// Whole 64-bit word holding addr, valid in the same cycle
	xlen_t rdata;

	modport master (output rd_en, wr_en, addr, wdata, strb, input rdata);
	modport slave (input rd_en, wr_en, addr, wdata, strb, output rdata);
	// Observer side, used by the pipeline register to pick load bytes
	modport monitor (input rd_en, wr_en, addr, wdata, strb, rdata);

endinterface

/* source/ex_unit.sv */
// ==============================
// Execute unit
// Integer ALU with the RV64 word forms,
// load/store address generation and
// store data lane alignment
// ==============================
`timescale 1ns/10ps

module ex_unit
	import ex_pkg::*;
(
	input  alu_op_e     alu_operation_i,
	input  logic        alu_add_sub_i,
	input  logic        alu_shift_i,
	input  logic        word_intercept_i,
	input  xlen_t       alu_op_num1_i,
	input  xlen_t       alu_op_num2_i,
	input  xlen_t       data_rs2_i,
	input  load_code_e  load_code_i,
	input  store_code_e store_code_i,

	output xlen_t       alu_result_o,
	mem_req_if.master   mem
);

	// Shift amount after masking for the word forms
	logic [5:0] shamt;
	// Adder output, also used for subtraction
	xlen_t      add_res;
	// Right shift source, prepared for the word forms
	xlen_t      srl_src;
	xlen_t      srl_res;
	// ALU result before the word sign extension
	xlen_t      raw_res;
	// Address adder, kept apart from the ALU adder
	xlen_t      agu_sum;
	// Byte position inside the 64-bit word
	logic [2:0] byte_off;
	// Byte enables before they are moved to the lane
	strb_t      strb_base;

	// Word forms use only five shift bits, so bit 5 is forced low
	assign shamt = word_intercept_i ? {1'b0, alu_op_num2_i[4:0]} : alu_op_num2_i[5:0];

	assign add_res = alu_add_sub_i ? (alu_op_num1_i - alu_op_num2_i)
	                               : (alu_op_num1_i + alu_op_num2_i);

	// SRLW shifts the zero-extended low half and SRAW the sign-extended one
	// Only the low 32 bits of either result survive, so both come out right
	always_comb begin
		if (!word_intercept_i) begin
			srl_src = alu_op_num1_i;
		end else if (alu_shift_i) begin
			srl_src = {{32{alu_op_num1_i[31]}}, alu_op_num1_i[31:0]};
		end else begin
			srl_src = {32'h0, alu_op_num1_i[31:0]};
		end
	end

	// Arithmetic shift when alu_shift_i is set
	assign srl_res = alu_shift_i ? xlen_t'($signed(srl_src) >>> shamt) : (srl_src >> shamt);

	// Function select
	always_comb begin
		case (alu_operation_i)
			ALU_ADD:  raw_res = add_res;
			ALU_SLL:  raw_res = alu_op_num1_i << shamt;
			ALU_SLT:  raw_res = ($signed(alu_op_num1_i) < $signed(alu_op_num2_i)) ? 64'd1 : 64'd0;
			ALU_SLTU: raw_res = (alu_op_num1_i < alu_op_num2_i) ? 64'd1 : 64'd0;
			ALU_XOR:  raw_res = alu_op_num1_i ^ alu_op_num2_i;
			ALU_SRL:  raw_res = srl_res;
			ALU_OR:   raw_res = alu_op_num1_i | alu_op_num2_i;
			ALU_AND:  raw_res = alu_op_num1_i & alu_op_num2_i;
			default:  raw_res = '0;
		endcase
	end

	// Word results keep the low half and copy bit 31 upward
	assign alu_result_o = word_intercept_i ? {{32{raw_res[31]}}, raw_res[31:0]} : raw_res;

	// Base plus offset, truncated to the 32-bit memory address
	assign agu_sum  = alu_op_num1_i + alu_op_num2_i;
	assign byte_off = agu_sum[2:0];

	// Enables come straight from the operation codes
	assign mem.rd_en = (load_code_i != LD_NONE);
	assign mem.wr_en = (store_code_i != ST_NONE);
	assign mem.addr  = agu_sum[31:0];

	// Store data moves up by whole bytes to its lane
	assign mem.wdata = data_rs2_i << {byte_off, 3'b000};

	// Byte count of the store
	always_comb begin
		case (store_code_i)
			SB:      strb_base = 8'h01;
			SH:      strb_base = 8'h03;
			SW:      strb_base = 8'h0f;
			SD:      strb_base = 8'hff;
			default: strb_base = 8'h00;
		endcase
	end

	// Alignment is assumed, so the shifted mask never runs off the word
	assign mem.strb = strb_base << byte_off;

endmodule

/* source/data_ram.sv */
// ==============================
// Data RAM
// 64-bit words with byte enables,
// combinational read and clocked write
// ==============================
`timescale 1ns/10ps

module data_ram
	import ex_pkg::*;
(
	input  logic     clk,
	input  logic     rst_i,
	input  logic     hold_i,
	mem_req_if.slave mem
);

	// Storage array, its contents are undefined until written
	xlen_t ram [RAM_WORDS];

	// Word index taken from the address bits above the byte offset
	logic [RAM_IDX_W-1:0] word_idx;

	// Store is allowed this cycle
	logic wr_go;

	assign word_idx = mem.addr[RAM_IDX_W+2:3];

	// The whole word is returned
	// Byte selection and extension happen in the pipeline register
	assign mem.rdata = ram[word_idx];

	// A held stage repeats its inputs next cycle, so the store must wait
	// No store lands while the core is in reset
	assign wr_go = mem.wr_en && !hold_i && !rst_i;

	// Only the lanes flagged in strb change
	always_ff @(posedge clk) begin
		if (wr_go) begin
			for (int b = 0; b < 8; b++) begin
				if (mem.strb[b]) begin
					ram[word_idx][8*b +: 8] <= mem.wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

/* source/ex_mem_reg.sv */
// ==============================
// EX/MEM pipeline register
// Picks ALU or load data, extends loads
// and holds the writeback record on a stall
// ==============================
`timescale 1ns/10ps

module ex_mem_reg
	import ex_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,
	input  logic       hold_i,

	input  xlen_t      alu_result_i,
	input  load_code_e load_code_i,
	input  reg_idx_t   addr_reg_wr_i,
	input  logic       reg_wr_en_i,
	mem_req_if.monitor mem,

	output reg_idx_t   addr_reg_wr_o,
	output xlen_t      data_reg_wr_o,
	output logic       reg_wr_en_o
);

	// Byte position of the load inside the returned word
	logic [2:0] byte_off;
	// Returned word with the addressed byte moved to bit 0
	xlen_t      lane;
	// Final writeback value
	xlen_t      wb_data;

	assign byte_off = mem.addr[2:0];
	assign lane     = mem.rdata >> {byte_off, 3'b000};

	// Loads take the memory data, everything else the ALU result
	always_comb begin
		wb_data = alu_result_i;
		if (mem.rd_en) begin
			case (load_code_i)
				LB:      wb_data = {{56{lane[7]}}, lane[7:0]};
				LH:      wb_data = {{48{lane[15]}}, lane[15:0]};
				LW:      wb_data = {{32{lane[31]}}, lane[31:0]};
				LD:      wb_data = lane;
				LBU:     wb_data = {56'h0, lane[7:0]};
				LHU:     wb_data = {48'h0, lane[15:0]};
				LWU:     wb_data = {32'h0, lane[31:0]};
				default: wb_data = alu_result_i;
			endcase
		end
	end

	// The record advances one step per unheld cycle
	// Reset leaves an empty record with the write enable low
	always_ff @(posedge clk) begin
		if (rst_i) begin
			addr_reg_wr_o <= '0;
			data_reg_wr_o <= '0;
			reg_wr_en_o   <= 1'b0;
		end else if (!hold_i) begin
			addr_reg_wr_o <= addr_reg_wr_i;
			data_reg_wr_o <= wb_data;
			reg_wr_en_o   <= reg_wr_en_i;
		end
	end

endmodule

/* source/ex_stage.sv */
// ==============================
// Execute stage top
// Decodes the hold level and links the ALU,
// the data RAM and the EX/MEM register
// ==============================
`timescale 1ns/10ps

module ex_stage
	import ex_pkg::*;
(
	input  logic        clk,
	input  logic        rst_i,

	input  hold_code_t  hold_code_i,

	input  alu_op_e     alu_operation_i,
	input  logic        alu_add_sub_i,
	input  logic        alu_shift_i,
	input  logic        word_intercept_i,
	input  xlen_t       alu_op_num1_i,
	input  xlen_t       alu_op_num2_i,
	input  xlen_t       data_rs2_i,
	input  load_code_e  load_code_i,
	input  store_code_e store_code_i,
	input  reg_idx_t    addr_reg_wr_i,
	input  logic        reg_wr_en_i,

	output xlen_t       alu_result_o,
	output reg_idx_t    addr_reg_wr_o,
	output xlen_t       data_reg_wr_o,
	output logic        reg_wr_en_o
);

	// Stage freeze, shared by the register and the RAM write port
	logic hold;

	// Request path between the execute unit and the RAM
	mem_req_if mem_bus ();

	assign hold = (hold_code_i >= HOLD_EX);

	ex_unit u_ex_unit (
		.alu_operation_i  (alu_operation_i),
		.alu_add_sub_i    (alu_add_sub_i),
		.alu_shift_i      (alu_shift_i),
		.word_intercept_i (word_intercept_i),
		.alu_op_num1_i    (alu_op_num1_i),
		.alu_op_num2_i    (alu_op_num2_i),
		.data_rs2_i       (data_rs2_i),
		.load_code_i      (load_code_i),
		.store_code_i     (store_code_i),
		.alu_result_o     (alu_result_o),
		.mem              (mem_bus.master)
	);

	data_ram u_data_ram (
		.clk    (clk),
		.rst_i  (rst_i),
		.hold_i (hold),
		.mem    (mem_bus.slave)
	);

	// The ALU result feeds the register from the top output
	ex_mem_reg u_ex_mem_reg (
		.clk           (clk),
		.rst_i         (rst_i),
		.hold_i        (hold),
		.alu_result_i  (alu_result_o),
		.load_code_i   (load_code_i),
		.addr_reg_wr_i (addr_reg_wr_i),
		.reg_wr_en_i   (reg_wr_en_i),
		.mem           (mem_bus.monitor),
		.addr_reg_wr_o (addr_reg_wr_o),
		.data_reg_wr_o (data_reg_wr_o),
		.reg_wr_en_o   (reg_wr_en_o)
	);

endmodule

/* tests/ex_stage_properties.sv */
// ==============================
// Execute stage properties
// Concurrent checks on the memory enables,
// the held record and the reset state
// ==============================
`timescale 1ns/10ps

module ex_stage_properties
	import ex_pkg::*;
(
	input logic     clk,
	input logic     rst_i,
	input logic     hold_i,
	input logic     rd_en_i,
	input logic     wr_en_i,
	input reg_idx_t addr_reg_wr_i,
	input xlen_t    data_reg_wr_i,
	input logic     reg_wr_en_i
);

	// Number of assertion failures, read by the testbench at the end
	int fail_count = 0;

	// A single request is either a load or a store
	mem_en_exclusive: assert property (@(posedge clk) !(rd_en_i && wr_en_i))
		else begin
			fail_count++;
			$error("Read and write enables are high in the same cycle");
		end

	// A held cycle leaves the whole writeback record as it was
	record_held: assert property (@(posedge clk) disable iff (rst_i)
		hold_i |=> $stable({addr_reg_wr_i, data_reg_wr_i, reg_wr_en_i}))
		else begin
			fail_count++;
			$error("Writeback record changed while the stage was held");
		end

	// Reset clears the write enable at the next edge
	wr_en_reset: assert property (@(posedge clk) rst_i |=> !reg_wr_en_i)
		else begin
			fail_count++;
			$error("Register write enable is high during reset");
		end

endmodule

bind ex_stage ex_stage_properties u_props (
	.clk           (clk),
	.rst_i         (rst_i),
	.hold_i        (hold),
	.rd_en_i       (mem_bus.rd_en),
	.wr_en_i       (mem_bus.wr_en),
	.addr_reg_wr_i (addr_reg_wr_o),
	.data_reg_wr_i (data_reg_wr_o),
	.reg_wr_en_i   (reg_wr_en_o)
);

/* tests/ex_stage_tb.sv */
// ==============================
// Execute stage testbench
// Random ALU, load, store and hold traffic
// checked against a behavioral model
// ==============================
`timescale 1ns/10ps

module ex_stage_tb
	import ex_pkg::*;
();

	localparam int RESET_CYCLES = 10;
	localparam int ALU_OPS      = 200;
	localparam int MEM_ROUNDS   = 40;
	localparam int HOLD_ROUNDS  = 8;
	localparam int MIX_OPS      = 600;
	// Every operation takes one cycle and the limit leaves twice that
	localparam int TIMEOUT_CYCLES = 2 * (2 + RAM_WORDS + ALU_OPS + MEM_ROUNDS * 8 +
		HOLD_ROUNDS * 2 + MIX_OPS) + RESET_CYCLES;

	logic        clk = 1'b0;
	logic        rst_i;
	hold_code_t  hold_code_i;
	alu_op_e     alu_operation_i;
	logic        alu_add_sub_i;
	logic        alu_shift_i;
	logic        word_intercept_i;
	xlen_t       alu_op_num1_i;
	xlen_t       alu_op_num2_i;
	xlen_t       data_rs2_i;
	load_code_e  load_code_i;
	store_code_e store_code_i;
	reg_idx_t    addr_reg_wr_i;
	logic        reg_wr_en_i;
	xlen_t       alu_result_o;
	reg_idx_t    addr_reg_wr_o;
	xlen_t       data_reg_wr_o;
	logic        reg_wr_en_o;

	// Expected writeback record and the shadow copy of the data RAM
	reg_idx_t    exp_idx = '0;
	xlen_t       exp_data = '0;
	logic        exp_en = 1'b0;
	xlen_t       shadow [RAM_WORDS];
	logic [31:0] seed;
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;

	ex_stage DUT (.*);

	always #5 clk = ~clk;

	// Run limit in case the stimulus stalls
	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic xlen_t random_word();
		return {next_random(), next_random()};
	endfunction

	// Random byte address aligned to an access of the given size
	function automatic addr_t aligned_addr(input int bytes);
		addr_t mask;
		mask = addr_t'(bytes - 1);
		return next_random() & ~mask;
	endfunction

	function automatic int store_bytes(input store_code_e sc);
		return 1 << (int'(sc) - 1);
	endfunction

	function automatic int load_bytes(input load_code_e lc);
		case (lc)
			LB, LBU: return 1;
			LH, LHU: return 2;
			LW, LWU: return 4;
			default: return 8;
		endcase
	endfunction

	// Word forms work on the 32-bit halves and sign-extend bit 31
	function automatic xlen_t alu_model(input alu_op_e op, input logic sub, sra, word,
		input xlen_t a, b);
		xlen_t       r;
		logic [31:0] w;
		int          sh;
		sh = word ? int'(b[4:0]) : int'(b[5:0]);
		case (op)
			ALU_ADD:  r = sub ? a - b : a + b;
			ALU_SLL:  r = a << sh;
			ALU_SLT:  r = {63'd0, $signed(a) < $signed(b)};
			ALU_SLTU: r = {63'd0, a < b};
			ALU_XOR:  r = a ^ b;
			ALU_OR:   r = a | b;
			ALU_AND:  r = a & b;
			default: begin
				if (word) begin
					if (sra) w = $signed(a[31:0]) >>> sh;
					else w = a[31:0] >> sh;
					r = {32'h0, w};
				end else if (sra) begin
					r = $signed(a) >>> sh;
				end else begin
					r = a >> sh;
				end
			end
		endcase
		if (word) r = xlen_t'($signed(r[31:0]));
		return r;
	endfunction

	function automatic xlen_t load_model(input load_code_e lc, input addr_t addr);
		xlen_t lane;
		lane = shadow[(addr >> 3) % RAM_WORDS] >> (8 * addr[2:0]);
		case (lc)
			LB:      return xlen_t'($signed(lane[7:0]));
			LH:      return xlen_t'($signed(lane[15:0]));
			LW:      return xlen_t'($signed(lane[31:0]));
			LBU:     return xlen_t'(lane[7:0]);
			LHU:     return xlen_t'(lane[15:0]);
			LWU:     return xlen_t'(lane[31:0]);
			default: return lane;
		endcase
	endfunction

	task automatic store_model(input store_code_e sc, input addr_t addr, input xlen_t data);
		for (int b = 0; b < store_bytes(sc); b++) begin
			shadow[(addr >> 3) % RAM_WORDS][8 * (addr[2:0] + b) +: 8] = data[8 * b +: 8];
		end
	endtask

	task automatic check_equal(input string what, input xlen_t got, input xlen_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_record();
		check_equal("addr_reg_wr_o", xlen_t'(addr_reg_wr_o), xlen_t'(exp_idx));
		check_equal("data_reg_wr_o", data_reg_wr_o, exp_data);
		check_equal("reg_wr_en_o", xlen_t'(reg_wr_en_o), xlen_t'(exp_en));
	endtask

	// Starts and ends at a falling edge and takes one cycle per operation
	task automatic apply_op(input alu_op_e op, input logic sub, sra, word,
		input xlen_t a, b, rs2, input load_code_e lc, input store_code_e sc,
		input reg_idx_t idx, input logic wen, input hold_code_t hc);
		xlen_t alu_exp;
		xlen_t wb_exp;
		addr_t addr;
		alu_operation_i  = op;
		alu_add_sub_i    = sub;
		alu_shift_i      = sra;
		word_intercept_i = word;
		alu_op_num1_i    = a;
		alu_op_num2_i    = b;
		data_rs2_i       = rs2;
		load_code_i      = lc;
		store_code_i     = sc;
		addr_reg_wr_i    = idx;
		reg_wr_en_i      = wen;
		hold_code_i      = hc;
		alu_exp = alu_model(op, sub, sra, word, a, b);
		addr    = addr_t'(a + b);
		wb_exp  = (lc != LD_NONE) ? load_model(lc, addr) : alu_exp;
		#1;
		check_equal("alu_result_o", alu_result_o, alu_exp);
		@(posedge clk);
		if (hc < HOLD_EX) begin
			exp_idx  = idx;
			exp_data = wb_exp;
			exp_en   = wen;
			if (sc != ST_NONE) store_model(sc, addr, rs2);
		end
		@(negedge clk);
		check_record();
	endtask

	// The operands are split at random but always add up to the address
	task automatic mem_op(input load_code_e lc, input store_code_e sc, input addr_t addr,
		input xlen_t rs2, input hold_code_t hc);
		xlen_t       base;
		logic [31:0] r;
		base = random_word();
		r    = next_random();
		apply_op(ALU_ADD, 1'b0, 1'b0, 1'b0, base, {next_random(), addr} - base, rs2,
			lc, sc, reg_idx_t'(r[4:0]), lc != LD_NONE, hc);
	endtask

	initial begin
		logic [31:0] r;
		addr_t       addr;
		load_code_e  lc;
		store_code_e sc;
		hold_code_t  hc;
		seed = 32'hd5a7;
		rst_i = 1'b1;
		hold_code_i = '0;
		alu_operation_i = ALU_ADD;
		{alu_add_sub_i, alu_shift_i, word_intercept_i} = '0;
		// Live values during reset, which a record without reset would capture
		reg_wr_en_i = 1'b1;
		addr_reg_wr_i = 5'd31;
		alu_op_num1_i = random_word();
		alu_op_num2_i = random_word();
		data_rs2_i = '0;
		load_code_i = LD_NONE;
		store_code_i = ST_NONE;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk);
			check_record();
		end
		rst_i = 1'b0;
		// Held operations right after reset must leave the empty record
		repeat (2) apply_op(ALU_ADD, 1'b0, 1'b0, 1'b0, random_word(), random_word(), '0,
			LD_NONE, ST_NONE, 5'd7, 1'b1, HOLD_EX);
		// Fill every RAM word so that later loads read known data
		for (int i = 0; i < RAM_WORDS; i++) begin
			r = next_random();
			mem_op(LD_NONE, SD, {r[31:9], 6'(i), 3'b000}, random_word(), '0);
		end
		for (int i = 0; i < ALU_OPS; i++) begin
			r = next_random();
			apply_op(alu_op_e'(r[2:0]), r[3], r[4], r[5], random_word(), random_word(),
				'0, LD_NONE, ST_NONE, reg_idx_t'(r[10:6]), r[11], '0);
		end
		// Each store is read back by every load code within the same word
		for (int k = 0; k < MEM_ROUNDS; k++) begin
			sc = store_code_e'(int'(SB) + k % 4);
			addr = aligned_addr(store_bytes(sc));
			mem_op(LD_NONE, sc, addr, random_word(), '0);
			for (int j = LB; j <= LWU; j++) begin
				lc = load_code_e'(j);
				mem_op(lc, ST_NONE, {addr[31:3], 3'b000} | (aligned_addr(load_bytes(lc)) & 32'h7),
					'0, '0);
			end
		end
		// Held stores are dropped while the unheld level just below still advances
		for (int k = 0; k < HOLD_ROUNDS; k++) begin
			r = next_random();
			addr = aligned_addr(8);
			hc = HOLD_EX + hold_code_t'(r % (8 - HOLD_EX));
			mem_op(LD_NONE, SD, addr, random_word(), hc);
			mem_op(LD, ST_NONE, addr, '0, HOLD_EX - 1);
		end
		for (int i = 0; i < MIX_OPS; i++) begin
			r = next_random();
			hc = (r[28:27] == 2'd0) ? hold_code_t'(r[31:29]) : 3'd0;
			case (r[1:0])
				2'd0: begin
					lc = load_code_e'(1 + r[4:2] % 7);
					mem_op(lc, ST_NONE, aligned_addr(load_bytes(lc)), '0, hc);
				end
				2'd1: begin
					sc = store_code_e'(1 + r[3:2]);
					mem_op(LD_NONE, sc, aligned_addr(store_bytes(sc)), random_word(), hc);
				end
				default: apply_op(alu_op_e'(r[4:2]), r[5], r[6], r[7], random_word(),
					random_word(), '0, LD_NONE, ST_NONE, reg_idx_t'(r[12:8]), r[13], hc);
			endcase
		end
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			DUT.u_props.fail_count);
		if (errors == 0 && DUT.u_props.fail_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* ex_stage.f */
source/ex_pkg.sv
source/mem_req_if.sv
source/ex_unit.sv
source/data_ram.sv
source/ex_mem_reg.sv
source/ex_stage.sv
tests/ex_stage_properties.sv
tests/ex_stage_tb.sv
